//--- design/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath width
`define DATA_W 32

// register number width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// instruction sub-fields
`define IMM_W 16
`define SHAMT_W 5

`endif

//--- design/mips_pkg.sv
package mips_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_SLTI  = 6'd10,
        OP_SW    = 6'd43
    } opcode_t;

    // function field of R-type words, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_t;

    // operation handed from decode to the EX stage
    // ALU_ADD is code 0, so a cleared ID/EX register carries an add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,  // signed compare
        ALU_SLL,
        ALU_SRL   // logical, zero fill
    } alu_op_t;

endpackage

//--- design/decode_ctrl.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module decode_ctrl
    import mips_pkg::*;
(
    input  logic [`DATA_W-1:0]     instr,
    input  logic                   instr_valid,

    output logic [`REG_ADDR_W-1:0] rs,
    output logic [`REG_ADDR_W-1:0] rt,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic [`SHAMT_W-1:0]    shamt,
    output logic [`DATA_W-1:0]     imm_ext,
    output logic                   alu_src,    // 1 selects the immediate
    output logic                   reg_dst,    // 1 writes rd, 0 writes rt
    output logic                   reg_write,
    output logic                   mem_write,
    output alu_op_t                alu_op
);

    opcode_t opcode;
    funct_t  funct;
    logic    dec_write;  // before the valid gate
    logic    dec_store;

    // fixed MIPS field positions
    assign opcode = opcode_t'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = funct_t'(instr[5:0]);

    assign imm_ext = {{(`DATA_W-`IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};

    always_comb begin
        alu_src   = 1'b0;
        reg_dst   = 1'b0;
        dec_write = 1'b0;
        dec_store = 1'b0;
        alu_op    = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                dec_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: dec_write = 1'b0;  // unknown funct
                endcase
            end
            OP_ADDI: begin
                alu_src   = 1'b1;
                dec_write = 1'b1;
                alu_op    = ALU_ADD;
            end
            OP_SLTI: begin
                alu_src   = 1'b1;
                dec_write = 1'b1;
                alu_op    = ALU_SLT;
            end
            OP_SW: begin
                alu_src   = 1'b1;  // address is rs + offset
                dec_store = 1'b1;
                alu_op    = ALU_ADD;
            end
            default: begin
                dec_write = 1'b0;  // unknown opcode, bubble
                dec_store = 1'b0;
            end
        endcase
    end

    // an empty slot or illegal word leaves no side effects
    assign reg_write = instr_valid & dec_write;
    assign mem_write = instr_valid & dec_store;

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,

    input  logic [`REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`REG_ADDR_W-1:0] rd_addr_b,
    output logic [`DATA_W-1:0]     rd_data_a,
    output logic [`DATA_W-1:0]     rd_data_b,

    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;  // r0 never written
        end
    end

    // the write of the current edge is visible to the next decode,
    // which is what keeps distance-2 hazards correct without a bypass
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

//--- design/id_ex.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module id_ex
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [`DATA_W-1:0]     pc_in,
    input  logic [`DATA_W-1:0]     reg_data1,  // rs value
    input  logic [`DATA_W-1:0]     reg_data2,  // rt value
    input  logic [`DATA_W-1:0]     imm_ext,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`SHAMT_W-1:0]    shamt,

    input  logic                   alu_src,
    input  logic                   reg_dst,
    input  logic                   reg_write,
    input  logic                   mem_write,
    input  alu_op_t                alu_op,

    output logic [`DATA_W-1:0]     pc_out,
    output logic [`DATA_W-1:0]     reg_data1_out,
    output logic [`DATA_W-1:0]     reg_data2_out,
    output logic [`DATA_W-1:0]     imm_ext_out,
    output logic [`REG_ADDR_W-1:0] rs_out,
    output logic [`REG_ADDR_W-1:0] rt_out,
    output logic [`REG_ADDR_W-1:0] rd_out,
    output logic [`SHAMT_W-1:0]    shamt_out,

    output logic                   alu_src_out,
    output logic                   reg_dst_out,
    output logic                   reg_write_out,
    output logic                   mem_write_out,
    output alu_op_t                alu_op_out
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_out        <= '0;
            reg_data1_out <= '0;
            reg_data2_out <= '0;
            imm_ext_out   <= '0;
            rs_out        <= '0;
            rt_out        <= '0;
            rd_out        <= '0;
            shamt_out     <= '0;

            // both write enables low, so a bubble is in flight
            alu_src_out   <= 1'b0;
            reg_dst_out   <= 1'b0;
            reg_write_out <= 1'b0;
            mem_write_out <= 1'b0;
            alu_op_out    <= ALU_ADD;
        end else begin
            pc_out        <= pc_in;
            reg_data1_out <= reg_data1;
            reg_data2_out <= reg_data2;
            imm_ext_out   <= imm_ext;
            rs_out        <= rs;
            rt_out        <= rt;
            rd_out        <= rd;
            shamt_out     <= shamt;

            alu_src_out   <= alu_src;
            reg_dst_out   <= reg_dst;
            reg_write_out <= reg_write;
            mem_write_out <= mem_write;
            alu_op_out    <= alu_op;
        end
    end

endmodule

//--- design/alu_exec.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module alu_exec
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic [`DATA_W-1:0]     pc,
    input  logic [`DATA_W-1:0]     reg_data1,
    input  logic [`DATA_W-1:0]     reg_data2,
    input  logic [`DATA_W-1:0]     imm_ext,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`SHAMT_W-1:0]    shamt,
    input  logic                   alu_src,
    input  logic                   reg_dst,
    input  logic                   reg_write,
    input  logic                   mem_write,
    input  alu_op_t                alu_op,

    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`DATA_W-1:0]     wb_data,
    output logic                   mem_write_q,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_wdata,
    output logic [`DATA_W-1:0]     res_pc,

    output logic [`DATA_W-1:0]     alu_result,    // register file write data
    output logic                   wr_en_next,
    output logic [`REG_ADDR_W-1:0] wr_addr_next
);

    logic [`DATA_W-1:0] fwd_a;
    logic [`DATA_W-1:0] fwd_b;
    logic [`DATA_W-1:0] op_b;

    // on a distance-1 hazard take the value still sitting in the result register
    assign fwd_a = (wb_en && wb_addr != '0 && wb_addr == rs) ? wb_data : reg_data1;
    assign fwd_b = (wb_en && wb_addr != '0 && wb_addr == rt) ? wb_data : reg_data2;

    assign op_b = alu_src ? imm_ext : fwd_b;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = fwd_a + op_b;
            ALU_SUB: alu_result = fwd_a - op_b;
            ALU_AND: alu_result = fwd_a & op_b;
            ALU_OR:  alu_result = fwd_a | op_b;
            ALU_SLT: alu_result = {{(`DATA_W-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
            ALU_SLL: alu_result = op_b << shamt;  // rs unused for shifts
            ALU_SRL: alu_result = op_b >> shamt;
            default: alu_result = '0;
        endcase
    end

    assign wr_addr_next = reg_dst ? rd : rt;
    assign wr_en_next   = reg_write && wr_addr_next != '0;  // r0 writes dropped here

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en       <= 1'b0;
            wb_addr     <= '0;
            wb_data     <= '0;
            mem_write_q <= 1'b0;
            mem_addr    <= '0;
            mem_wdata   <= '0;
            res_pc      <= '0;
        end else begin
            wb_en       <= wr_en_next;
            wb_addr     <= wr_addr_next;
            wb_data     <= alu_result;
            mem_write_q <= mem_write;
            mem_addr    <= alu_result;  // sw decodes to rs + imm
            mem_wdata   <= fwd_b;
            res_pc      <= pc;
        end
    end

endmodule

//--- design/exec_core.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module exec_core
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   instr_valid,
    input  logic [`DATA_W-1:0]     instr,
    input  logic [`DATA_W-1:0]     pc,

    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`DATA_W-1:0]     wb_data,
    output logic                   mem_write,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_wdata,
    output logic [`DATA_W-1:0]     res_pc
);

    // decode stage
    logic [`REG_ADDR_W-1:0] id_rs, id_rt, id_rd;
    logic [`SHAMT_W-1:0]    id_shamt;
    logic [`DATA_W-1:0]     id_imm, id_data1, id_data2;
    logic                   id_alu_src, id_reg_dst, id_reg_write, id_mem_write;
    alu_op_t                id_alu_op;

    // execute stage
    logic [`DATA_W-1:0]     ex_pc, ex_data1, ex_data2, ex_imm;
    logic [`REG_ADDR_W-1:0] ex_rs, ex_rt, ex_rd;
    logic [`SHAMT_W-1:0]    ex_shamt;
    logic                   ex_alu_src, ex_reg_dst, ex_reg_write, ex_mem_write;
    alu_op_t                ex_alu_op;

    // register file write from EX
    logic [`DATA_W-1:0]     rf_wr_data;
    logic                   rf_wr_en;
    logic [`REG_ADDR_W-1:0] rf_wr_addr;

    decode_ctrl decode_i (
        .instr(instr), .instr_valid(instr_valid),
        .rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt), .imm_ext(id_imm),
        .alu_src(id_alu_src), .reg_dst(id_reg_dst), .reg_write(id_reg_write),
        .mem_write(id_mem_write), .alu_op(id_alu_op)
    );

    reg_file reg_file_i (
        .clk(clk), .reset(reset),
        .rd_addr_a(id_rs), .rd_addr_b(id_rt),
        .rd_data_a(id_data1), .rd_data_b(id_data2),
        .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data)
    );

    id_ex id_ex_i (
        .clk(clk), .reset(reset),
        .pc_in(pc), .reg_data1(id_data1), .reg_data2(id_data2), .imm_ext(id_imm),
        .rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt),
        .alu_src(id_alu_src), .reg_dst(id_reg_dst), .reg_write(id_reg_write),
        .mem_write(id_mem_write), .alu_op(id_alu_op),
        .pc_out(ex_pc), .reg_data1_out(ex_data1), .reg_data2_out(ex_data2),
        .imm_ext_out(ex_imm), .rs_out(ex_rs), .rt_out(ex_rt), .rd_out(ex_rd),
        .shamt_out(ex_shamt), .alu_src_out(ex_alu_src), .reg_dst_out(ex_reg_dst),
        .reg_write_out(ex_reg_write), .mem_write_out(ex_mem_write),
        .alu_op_out(ex_alu_op)
    );

    alu_exec alu_exec_i (
        .clk(clk), .reset(reset),
        .pc(ex_pc), .reg_data1(ex_data1), .reg_data2(ex_data2), .imm_ext(ex_imm),
        .rs(ex_rs), .rt(ex_rt), .rd(ex_rd), .shamt(ex_shamt),
        .alu_src(ex_alu_src), .reg_dst(ex_reg_dst), .reg_write(ex_reg_write),
        .mem_write(ex_mem_write), .alu_op(ex_alu_op),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .mem_write_q(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .res_pc(res_pc),
        .alu_result(rf_wr_data), .wr_en_next(rf_wr_en), .wr_addr_next(rf_wr_addr)
    );

endmodule

//--- testbench/exec_core_chk.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module exec_core_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   wb_en,
    input logic [`REG_ADDR_W-1:0] wb_addr,
    input logic                   mem_write
);

    // a store never writes back
    no_dual_strobe: assert property (@(posedge clk) disable iff (reset)
        !(wb_en && mem_write))
        else $error("wb_en and mem_write high together");

    wb_not_r0: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> wb_addr != '0)
        else $error("write-back to register 0");

    // first edge after reset release
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!wb_en && !mem_write))
        else $error("strobe active right after reset");

endmodule

bind exec_core exec_core_chk chk_i (.*);

//--- testbench/exec_core_tb.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module exec_core_tb
    import mips_pkg::*;
;

    typedef struct packed {
        logic                   wb_en;
        logic [`REG_ADDR_W-1:0] wb_addr;
        logic [`DATA_W-1:0]     wb_data;
        logic                   mem_write;
        logic [`DATA_W-1:0]     mem_addr;
        logic [`DATA_W-1:0]     mem_wdata;
        logic [`DATA_W-1:0]     pc;
    } exp_t;

    localparam int NUM_INSTR = 400;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [`DATA_W-1:0]     instr;
    logic [`DATA_W-1:0]     pc;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`DATA_W-1:0]     wb_data;
    logic                   mem_write;
    logic [`DATA_W-1:0]     mem_addr;
    logic [`DATA_W-1:0]     mem_wdata;
    logic [`DATA_W-1:0]     res_pc;

    integer             seed = 43;
    logic [`DATA_W-1:0] model_regs [`NUM_REGS];  // architectural state in program order
    exp_t               exp_q [$];
    int                 checked = 0;

    exec_core dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic field_check(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            fail_stop();
        end
    endtask

    // sequential semantics of one instruction
    function automatic exp_t ref_model(input logic valid, input logic [31:0] w,
                                       input logic [31:0] p);
        exp_t                   e;
        opcode_t                op;
        funct_t                 fn;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`DATA_W-1:0]     imm;
        logic [`DATA_W-1:0]     res;
        logic [`REG_ADDR_W-1:0] dst;
        logic                   wr;
        e   = '0;
        e.pc = p;
        op  = opcode_t'(w[31:26]);
        fn  = funct_t'(w[5:0]);
        a   = model_regs[w[25:21]];
        b   = model_regs[w[20:16]];
        imm = {{16{w[15]}}, w[15:0]};
        wr  = 1'b0;
        res = '0;
        dst = w[20:16];
        if (valid) begin
            case (op)
                OP_RTYPE: begin
                    dst = w[15:11];
                    wr  = 1'b1;
                    case (fn)
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << w[10:6];
                        FN_SRL:  res = b >> w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: begin
                    wr  = 1'b1;
                    res = a + imm;
                end
                OP_SLTI: begin
                    wr  = 1'b1;
                    res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                end
                OP_SW: begin
                    e.mem_write = 1'b1;
                    e.mem_addr  = a + imm;
                    e.mem_wdata = b;
                end
                default: wr = 1'b0;
            endcase
        end
        if (wr && dst != '0) begin
            e.wb_en    = 1'b1;
            e.wb_addr  = dst;
            e.wb_data  = res;
            model_regs[dst] = res;
        end
        return e;
    endfunction

    // mostly r0..r7 so hazards are frequent
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[6:4] != 3'd0) ? {2'b00, r[2:0]} : r[4:0];
    endfunction

    task automatic issue(input logic valid, input logic [31:0] w);
        instr_valid = valid;
        instr       = w;
        exp_q.push_back(ref_model(valid, w, pc));
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] w;
        funct_t      fns [7];
        fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL, FN_SRL};
        r = $random(seed);
        w = $random(seed);
        case ({28'd0, r[3:0]} % 12)
            0, 1, 2, 3, 4, 5, 6:
                issue(1'b1, {OP_RTYPE, pick_reg(), pick_reg(), pick_reg(), w[10:6],
                             fns[{28'd0, r[3:0]} % 12]});
            7:  issue(1'b1, {OP_ADDI, pick_reg(), pick_reg(), w[15:0]});
            8:  issue(1'b1, {OP_SLTI, pick_reg(), pick_reg(), w[15:0]});
            9:  issue(1'b1, {OP_SW, pick_reg(), pick_reg(), w[15:0]});
            10: issue(1'b1, {OP_RTYPE, pick_reg(), pick_reg(), pick_reg(), 5'd0, 6'd39});
            default: begin
                if (r[8]) begin
                    issue(1'b1, {6'd35, w[25:0]});  // unknown opcode
                end else begin
                    // legal word in an empty slot
                    issue(1'b0, {(r[9] ? OP_SW : OP_ADDI), pick_reg(), pick_reg(),
                                 w[15:0]});
                end
            end
        endcase
    endtask

    initial begin
        int waited;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = 32'h100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        waited = 0;
        while (reset) begin
            @(negedge clk);
            waited++;
            if (waited > 10) begin
                $display("timeout waiting for reset release");
                fail_stop();
            end
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            issue_random();
            @(negedge clk);
            pc = pc + 4;
        end
        waited = 0;
        while (checked < NUM_INSTR) begin
            issue(1'b0, '0);  // bubbles push the tail out
            @(negedge clk);
            pc = pc + 4;
            waited++;
            if (waited > 20) begin
                $display("timeout draining the pipeline");
                fail_stop();
            end
        end
        if (checked >= NUM_INSTR) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // result of entry k is visible at the second rising edge after it was sampled
    always @(posedge clk) begin
        exp_t e;
        if (!reset) begin
            if (exp_q.size() >= 3) begin
                e = exp_q.pop_front();
                field_check("wb_en", {31'd0, wb_en}, {31'd0, e.wb_en});
                field_check("mem_write", {31'd0, mem_write}, {31'd0, e.mem_write});
                field_check("res_pc", res_pc, e.pc);
                if (e.wb_en) begin
                    field_check("wb_addr", {27'd0, wb_addr}, {27'd0, e.wb_addr});
                    field_check("wb_data", wb_data, e.wb_data);
                end
                if (e.mem_write) begin
                    field_check("mem_addr", mem_addr, e.mem_addr);
                    field_check("mem_wdata", mem_wdata, e.mem_wdata);
                end
                checked++;
            end else begin
                // nothing issued has arrived yet, outputs still cleared
                field_check("wb_en", {31'd0, wb_en}, 32'd0);
                field_check("mem_write", {31'd0, mem_write}, 32'd0);
                field_check("wb_addr", {27'd0, wb_addr}, 32'd0);
                field_check("wb_data", wb_data, 32'd0);
                field_check("mem_addr", mem_addr, 32'd0);
                field_check("mem_wdata", mem_wdata, 32'd0);
                field_check("res_pc", res_pc, 32'd0);
            end
        end
    end

endmodule

//--- files.f
+incdir+design
design/mips_pkg.sv
design/decode_ctrl.sv
design/reg_file.sv
design/id_ex.sv
design/alu_exec.sv
design/exec_core.sv
testbench/exec_core_chk.sv
testbench/exec_core_tb.sv

//--- run.sh
#!/bin/bash
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module exec_core_tb -f files.f -o Vexec_core_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vexec_core_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
